/* Bender.yml */
package:
  name: gcm_enc

sources:
  - gcm_pkg.sv
  - gcm_block_fifo.sv
  - gcm_loader.sv
  - gcm_ctr_path.sv
  - gcm_ghash.sv
  - gcm_tag_out.sv
  - gcm_enc_top.sv
  - target: test
    files:
      - gcm_enc_asserts.sv
      - tb_gcm_enc.sv

/* gcm_block_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_block_fifo #(
	parameter type payload_t = logic [127:0],
	parameter int  DEPTH     = 8
) (
	input  wire      clk,
	input  wire      reset,
	input  wire      clear,    // Empties the queue, contents left as they are
	input  wire      wr,
	input  payload_t wr_data,
	input  wire      rd,
	output payload_t rd_data,  // Head, valid while not empty
	output logic     empty,
	output logic     full
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_wr, do_rd;

	assign do_wr   = wr & ~full;   // Writes into a full queue are dropped
	assign do_rd   = rd & ~empty;
	assign empty   = (count == '0);
	assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign rd_data = mem[rd_ptr];  // Show-ahead

	always_ff @(posedge clk) begin
		if (!reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;                     // Both or neither, level unchanged
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

/* gcm_ctr_path.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_ctr_path (
	input  wire                         clk,
	input  wire                         reset,
	input  wire [gcm_pkg::IV_BITS-1:0]  iv,
	input  wire                         iv_valid,
	input  gcm_pkg::len_t               len,
	input  wire                         len_valid,
	input  gcm_pkg::block_t             pt_block,
	input  wire                         pt_empty,
	input  wire                         cipher_ack,
	input  gcm_pkg::block_t             keystream,
	input  wire                         ghash_busy,
	input  wire                         out_full,
	output logic                        pt_rd,
	output logic                        cipher_req,
	output gcm_pkg::block_t             cipher_block,
	output gcm_pkg::block_t             h,
	output logic                        h_valid,
	output gcm_pkg::block_t             ej0,
	output logic                        ej0_valid,
	output gcm_pkg::block_t             ct_block,
	output logic                        ct_valid
);

	import gcm_pkg::*;

	typedef enum logic [2:0] {
		CP_H_REQ, CP_H_WAIT, CP_IDLE, CP_J0_WAIT, CP_BLK, CP_KS_WAIT, CP_XOR
	} ctr_state_t;

	ctr_state_t                  state;
	logic [IV_BITS-1:0]          iv_q;
	logic [CTR_BITS-1:0]         ctr;
	logic [$clog2(BLOCK_BITS)-1:0] tail_bits;  // Valid bits in the last block, 0 for full
	blk_cnt_t                    blk_left;
	logic                        j0_pend;
	logic                        issue_j0, issue_blk, last_blk;
	block_t                      ks_q, keep_mask;

	assign issue_j0  = (state == CP_IDLE) & j0_pend;
	assign issue_blk = (state == CP_BLK) & ~pt_empty;  // Keystream only once data is queued
	assign last_blk  = (blk_left == blk_cnt_t'(1));

	// Clear GCM bits from tail_bits on in the final block
	assign keep_mask = (last_blk && tail_bits != '0) ? ~({BLOCK_BITS{1'b1}} >> tail_bits) : '1;
	assign ct_block  = (ks_q ^ pt_block) & keep_mask;
	assign ct_valid  = (state == CP_XOR) & ~ghash_busy & ~out_full;  // Hash and queue both free
	assign pt_rd     = ct_valid;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state      <= CP_H_REQ;
			cipher_req <= 1'b0;
			h          <= '0;                // Reads as zero until E(0) returns
			h_valid    <= 1'b0;
			ej0_valid  <= 1'b0;
			j0_pend    <= 1'b0;
			blk_left   <= '0;
		end else begin
			cipher_req <= 1'b0;
			if (iv_valid)
				ej0_valid <= 1'b0;           // Previous message's E(J0) retired
			if (len_valid) begin
				j0_pend  <= 1'b1;            // J0 once the block count is known
				blk_left <= blocks_of(len.pt_bits);
			end
			case (state)
				CP_H_REQ: begin
					cipher_req <= 1'b1;      // E(0), first request after reset
					state      <= CP_H_WAIT;
				end
				CP_H_WAIT: if (cipher_ack) begin
					h       <= keystream;
					h_valid <= 1'b1;
					state   <= CP_IDLE;
				end
				CP_IDLE: if (issue_j0) begin
					cipher_req <= 1'b1;
					j0_pend    <= 1'b0;
					state      <= CP_J0_WAIT;
				end
				CP_J0_WAIT: if (cipher_ack) begin
					ej0_valid <= 1'b1;
					state     <= (blk_left != '0) ? CP_BLK : CP_IDLE;
				end
				CP_BLK: if (issue_blk) begin
					cipher_req <= 1'b1;
					state      <= CP_KS_WAIT;
				end
				CP_KS_WAIT: if (cipher_ack) state <= CP_XOR;
				CP_XOR: if (ct_valid) begin
					blk_left <= blk_left - 1'b1;
					state    <= last_blk ? CP_IDLE : CP_BLK;
				end
				default: state <= CP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (iv_valid)
			iv_q <= iv;
		if (len_valid)
			tail_bits <= len.pt_bits[$clog2(BLOCK_BITS)-1:0];
		if (state == CP_H_REQ)
			cipher_block <= '0;
		if (issue_j0) begin
			cipher_block <= {iv_q, CTR_BITS'(1)};  // J0
			ctr          <= CTR_BITS'(2);           // Data counters start at 2
		end
		if (issue_blk) begin
			cipher_block <= {iv_q, ctr};
			ctr          <= ctr + 1'b1;
		end
		if (state == CP_J0_WAIT && cipher_ack)
			ej0 <= keystream;
		if (state == CP_KS_WAIT && cipher_ack)
			ks_q <= keystream;
	end

endmodule

`default_nettype wire

/* gcm_enc.f */
gcm_pkg.sv
gcm_block_fifo.sv
gcm_loader.sv
gcm_ctr_path.sv
gcm_ghash.sv
gcm_tag_out.sv
gcm_enc_top.sv
gcm_enc_asserts.sv
tb_gcm_enc.sv

/* gcm_enc_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_enc_asserts (
	input wire             clk,
	input wire             reset,
	input gcm_pkg::block_t out_data,
	input wire             out_valid,
	input wire             tag_data_out,
	input wire             ready_to_out,
	input wire             cipher_req,
	input wire             cipher_ack,
	input wire             ready_for_inp,
	input gcm_pkg::len_t   len,
	input wire             len_valid,
	input wire             pt_wr,
	input wire             msg_done
);

	import gcm_pkg::*;

	int          assert_fails = 0;
	logic        req_open;   // Cipher request waiting for its acknowledge
	logic        sealed;     // Last plaintext word taken, tag not yet out
	logic [15:0] pt_left;

	always_ff @(posedge clk) begin
		if (!reset) begin
			req_open <= 1'b0;
			sealed   <= 1'b0;
			pt_left  <= '0;
		end else begin
			if (cipher_req)
				req_open <= 1'b1;
			else if (cipher_ack)
				req_open <= 1'b0;
			if (len_valid)
				pt_left <= len.pt_bits;
			if (pt_wr) begin
				pt_left <= (pt_left > 16'd128) ? pt_left - 16'd128 : '0;
				if (pt_left <= 16'd128)
					sealed <= 1'b1;
			end
			if (msg_done)
				sealed <= 1'b0;
		end
	end

	beat_hold: assert property (@(posedge clk) disable iff (!reset)
		out_valid && !ready_to_out |=> out_valid && $stable(out_data) && $stable(tag_data_out))
		else begin
			$error("Output beat changed while stalled");
			assert_fails++;
		end

	one_request: assert property (@(posedge clk) disable iff (!reset)
		cipher_req |-> !req_open)
		else begin
			$error("Cipher request issued while one is outstanding");
			assert_fails++;
		end

	input_closed: assert property (@(posedge clk) disable iff (!reset)
		sealed |-> !ready_for_inp)
		else begin
			$error("Input ready before the tag left");
			assert_fails++;
		end

endmodule

bind gcm_enc_top gcm_enc_asserts i_gcm_enc_asserts (
	.clk (clk), .reset (reset),
	.out_data (out_data), .out_valid (out_valid), .tag_data_out (tag_data_out),
	.ready_to_out (ready_to_out),
	.cipher_req (cipher_req), .cipher_ack (cipher_ack),
	.ready_for_inp (ready_for_inp),
	.len (len), .len_valid (len_valid), .pt_wr (pt_wr), .msg_done (msg_done)
);

`default_nettype wire

/* gcm_enc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_enc_top (
	input  wire              clk,
	input  wire              reset,
	input  gcm_pkg::block_t  in_data,
	input  wire              in_valid,
	output logic             ready_for_inp,
	output gcm_pkg::block_t  out_data,
	output logic             out_valid,
	output logic             tag_data_out,
	input  wire              ready_to_out,
	output logic             cipher_req,
	output gcm_pkg::block_t  cipher_block,
	input  wire              cipher_ack,
	input  gcm_pkg::block_t  keystream
);

	import gcm_pkg::*;

	logic [IV_BITS-1:0] iv;
	len_t               len;
	block_t             aad_block, pt_data, pt_block, h, ej0, ct_block, ghash_result;
	logic               iv_valid, len_valid, aad_valid, pt_wr, fifo_clear;
	logic               pt_rd, pt_empty, ghash_busy, ghash_done, ct_valid, out_full, msg_done;

	gcm_loader i_loader (
		.clk (clk), .reset (reset),
		.in_data (in_data), .in_valid (in_valid), .ghash_busy (ghash_busy),
		.msg_done (msg_done), .ready_for_inp (ready_for_inp),
		.iv (iv), .iv_valid (iv_valid), .len (len), .len_valid (len_valid),
		.aad_block (aad_block), .aad_valid (aad_valid),
		.pt_wr (pt_wr), .pt_data (pt_data), .fifo_clear (fifo_clear)
	);

	// Never fills, the loader stops at PT_MAX_BLOCKS
	gcm_block_fifo #(.payload_t (block_t), .DEPTH (IN_FIFO_DEPTH)) i_pt_fifo (
		.clk (clk), .reset (reset), .clear (fifo_clear),
		.wr (pt_wr), .wr_data (pt_data), .rd (pt_rd),
		.rd_data (pt_block), .empty (pt_empty), .full ()
	);

	gcm_ctr_path i_ctr_path (
		.clk (clk), .reset (reset),
		.iv (iv), .iv_valid (iv_valid), .len (len), .len_valid (len_valid),
		.pt_block (pt_block), .pt_empty (pt_empty),
		.cipher_ack (cipher_ack), .keystream (keystream),
		.ghash_busy (ghash_busy), .out_full (out_full), .pt_rd (pt_rd),
		.cipher_req (cipher_req), .cipher_block (cipher_block),
		.h (h), .h_valid (), .ej0 (ej0), .ej0_valid (),  // Status levels, observed only
		.ct_block (ct_block), .ct_valid (ct_valid)
	);

	gcm_ghash i_ghash (
		.clk (clk), .reset (reset), .h (h),
		.len (len), .len_valid (len_valid),
		.aad_block (aad_block), .aad_valid (aad_valid),
		.ct_block (ct_block), .ct_valid (ct_valid),
		.ghash_busy (ghash_busy), .ghash_result (ghash_result), .ghash_done (ghash_done)
	);

	gcm_tag_out i_tag_out (
		.clk (clk), .reset (reset),
		.ct_block (ct_block), .ct_valid (ct_valid), .ej0 (ej0),
		.ghash_result (ghash_result), .ghash_done (ghash_done),
		.ready_to_out (ready_to_out), .out_full (out_full),
		.out_data (out_data), .tag_data_out (tag_data_out),
		.out_valid (out_valid), .msg_done (msg_done)
	);

endmodule

`default_nettype wire

/* gcm_ghash.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_ghash (
	input  wire              clk,
	input  wire              reset,
	input  gcm_pkg::block_t  h,
	input  gcm_pkg::len_t    len,
	input  wire              len_valid,
	input  gcm_pkg::block_t  aad_block,
	input  wire              aad_valid,
	input  gcm_pkg::block_t  ct_block,
	input  wire              ct_valid,
	output logic             ghash_busy,
	output gcm_pkg::block_t  ghash_result,
	output logic             ghash_done
);

	import gcm_pkg::*;

	// Multiply by x, one step right in GCM bit order
	function automatic block_t mul_x(input block_t a);
		return (a >> 1) ^ (a[0] ? GF_R : '0);
	endfunction

	logic                          loading;     // Load cycle, latches H
	logic                          len_fold;    // Running multiply is the length block
	logic                          fold_pend;   // Length block still owed
	logic [$clog2(BLOCK_BITS)-1:0] bit_cnt;
	blk_cnt_t                      aad_left, ct_left;
	len_t                          len_q;
	block_t                        acc, z, v, hs;
	block_t                        len_block, in_sel, z_next;
	logic                          fold_go, start;

	assign len_block = {48'd0, len_q.aad_bits, 48'd0, len_q.pt_bits};
	assign fold_go   = fold_pend & ~ghash_busy & (aad_left == '0) & (ct_left == '0);
	assign start     = aad_valid | ct_valid | fold_go;
	assign z_next    = hs[BLOCK_BITS-1] ? (z ^ v) : z;  // H bit i adds V * x^i
	assign ghash_result = acc;

	always_comb begin
		if (aad_valid)     in_sel = aad_block;
		else if (ct_valid) in_sel = ct_block;
		else               in_sel = len_block;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			ghash_busy <= 1'b0;
			ghash_done <= 1'b0;
			loading    <= 1'b0;
			len_fold   <= 1'b0;
			fold_pend  <= 1'b0;
			bit_cnt    <= '0;
			aad_left   <= '0;
			ct_left    <= '0;
		end else begin
			ghash_done <= 1'b0;
			if (len_valid) begin
				aad_left  <= blocks_of(len.aad_bits);
				ct_left   <= blocks_of(len.pt_bits);
				fold_pend <= 1'b1;
			end
			if (start) begin
				ghash_busy <= 1'b1;
				loading    <= 1'b1;
				len_fold   <= fold_go;
				bit_cnt    <= '0;
				if (aad_valid) aad_left  <= aad_left - 1'b1;
				if (ct_valid)  ct_left   <= ct_left - 1'b1;
				if (fold_go)   fold_pend <= 1'b0;
			end else if (loading) begin
				if (|h) loading <= 1'b0;  // E(0) comes back shortly after reset
			end else if (ghash_busy) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == '1) begin
					ghash_busy <= 1'b0;
					ghash_done <= len_fold;      // Tag hash complete
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (len_valid) begin
			acc   <= '0;                         // New message
			len_q <= len;                        // Kept for the length block
		end
		if (start) begin
			v <= acc ^ in_sel;
			z <= '0;
		end else if (loading) begin
			hs <= h;
		end else if (ghash_busy) begin
			z  <= z_next;
			v  <= mul_x(v);
			hs <= hs << 1;                       // Next H bit into the MSB
			if (bit_cnt == '1)
				acc <= z_next;
		end
	end

endmodule

`default_nettype wire

/* gcm_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_loader (
	input  wire                           clk,
	input  wire                           reset,
	input  gcm_pkg::block_t               in_data,
	input  wire                           in_valid,
	input  wire                           ghash_busy,
	input  wire                           msg_done,
	output logic                          ready_for_inp,
	output logic [gcm_pkg::IV_BITS-1:0]   iv,
	output logic                          iv_valid,
	output gcm_pkg::len_t                 len,
	output logic                          len_valid,
	output gcm_pkg::block_t               aad_block,
	output logic                          aad_valid,
	output logic                          pt_wr,
	output gcm_pkg::block_t               pt_data,
	output logic                          fifo_clear
);

	import gcm_pkg::*;

	load_state_t state;
	logic        alive;            // Set one cycle after reset ends
	logic        accept;
	logic [15:0] aad_rem, pt_rem;  // Bits still to come per section

	assign ready_for_inp = alive & ~ghash_busy & (state != LD_WAIT);
	assign accept        = in_valid & ready_for_inp;

	// Words go straight through, strobes mark which kind was taken
	assign iv         = in_data[BLOCK_BITS-1 -: IV_BITS];  // Upper 96 bits
	assign len        = '{aad_bits: in_data[79:64], pt_bits: in_data[15:0]};
	assign aad_block  = in_data;
	assign pt_data    = in_data;
	assign iv_valid   = accept & (state == LD_IV);
	assign len_valid  = accept & (state == LD_SIZE);
	assign aad_valid  = accept & (state == LD_AAD);
	assign pt_wr      = accept & (state == LD_PT);
	assign fifo_clear = len_valid;                          // Fresh plaintext queue per message

	always_ff @(posedge clk) begin
		if (!reset) begin
			state   <= LD_IV;
			alive   <= 1'b0;
			aad_rem <= '0;
			pt_rem  <= '0;
		end else begin
			alive <= 1'b1;
			case (state)
				LD_IV: if (accept) state <= LD_SIZE;
				LD_SIZE: if (accept) begin
					aad_rem <= len.aad_bits;
					pt_rem  <= len.pt_bits;
					if (len.aad_bits != '0)      state <= LD_AAD;  // Empty sections skipped
					else if (len.pt_bits != '0)  state <= LD_PT;
					else                         state <= LD_WAIT;
				end
				LD_AAD: if (accept) begin
					aad_rem <= (aad_rem > 16'(BLOCK_BITS)) ? aad_rem - 16'(BLOCK_BITS) : '0;
					if (aad_rem <= 16'(BLOCK_BITS))
						state <= (pt_rem != '0) ? LD_PT : LD_WAIT;
				end
				LD_PT: if (accept) begin
					pt_rem <= (pt_rem > 16'(BLOCK_BITS)) ? pt_rem - 16'(BLOCK_BITS) : '0;
					if (pt_rem <= 16'(BLOCK_BITS))
						state <= LD_WAIT;
				end
				LD_WAIT: if (msg_done) state <= LD_IV;             // Tag has left
				default: state <= LD_IV;
			endcase
		end
	end

endmodule

`default_nettype wire

/* gcm_pkg.sv */
`default_nettype none

package gcm_pkg;

	localparam int BLOCK_BITS     = 128;                   // One GCM block
	localparam int IV_BITS        = 96;                    // IV part of a counter block
	localparam int CTR_BITS       = BLOCK_BITS - IV_BITS;  // 32-bit block counter
	localparam int AAD_MAX_BLOCKS = 2;
	localparam int PT_MAX_BLOCKS  = 8;
	localparam int IN_FIFO_DEPTH  = PT_MAX_BLOCKS;
	localparam int OUT_FIFO_DEPTH = PT_MAX_BLOCKS + 1;     // Ciphertext beats plus the tag

	// Block counters cover the larger of the two sections
	localparam int MAX_BLOCKS   = (AAD_MAX_BLOCKS > PT_MAX_BLOCKS) ? AAD_MAX_BLOCKS : PT_MAX_BLOCKS;
	localparam int BLK_CNT_BITS = $clog2(MAX_BLOCKS + 1);

	// Vector MSB is GCM bit 0
	typedef logic [BLOCK_BITS-1:0] block_t;
	typedef logic [BLK_CNT_BITS-1:0] blk_cnt_t;

	// Reduction constant, x^128 + x^7 + x^2 + x + 1 in reflected order
	localparam block_t GF_R = {8'he1, 120'd0};

	typedef struct packed {
		logic [15:0] aad_bits;  // Size word bits 79..64
		logic [15:0] pt_bits;   // Size word bits 15..0
	} len_t;

	typedef struct packed {
		block_t data;
		logic   is_tag;         // Last beat of a message
	} out_beat_t;

	typedef enum logic [2:0] {
		LD_IV,
		LD_SIZE,
		LD_AAD,
		LD_PT,
		LD_WAIT
	} load_state_t;

	// Number of 128-bit blocks needed for a bit length, rounded up
	function automatic blk_cnt_t blocks_of(input logic [15:0] bits);
		logic [16:0] padded;
		padded = {1'b0, bits} + 17'(BLOCK_BITS - 1);
		return blk_cnt_t'(padded >> $clog2(BLOCK_BITS));
	endfunction

endpackage

`default_nettype wire

/* gcm_tag_out.sv */
`timescale 1ns/1ps
`default_nettype none

module gcm_tag_out (
	input  wire              clk,
	input  wire              reset,
	input  gcm_pkg::block_t  ct_block,
	input  wire              ct_valid,
	input  gcm_pkg::block_t  ej0,
	input  gcm_pkg::block_t  ghash_result,
	input  wire              ghash_done,
	input  wire              ready_to_out,
	output logic             out_full,
	output gcm_pkg::block_t  out_data,
	output logic             tag_data_out,
	output logic             out_valid,
	output logic             msg_done
);

	import gcm_pkg::*;

	out_beat_t wr_beat, head;
	logic      tag_wr, fifo_wr, fifo_rd, fifo_empty;

	assign fifo_wr = ct_valid | tag_wr;
	assign fifo_rd = ~fifo_empty & (~out_valid | ready_to_out);  // Refill the output register
	assign msg_done = out_valid & ready_to_out & tag_data_out;

	always_comb begin
		wr_beat.data   = tag_wr ? (ghash_result ^ ej0) : ct_block;  // Tag is GHASH xor E(J0)
		wr_beat.is_tag = tag_wr;
	end

	gcm_block_fifo #(
		.payload_t (out_beat_t),
		.DEPTH     (OUT_FIFO_DEPTH)
	) i_out_fifo (
		.clk     (clk),
		.reset   (reset),
		.clear   (1'b0),
		.wr      (fifo_wr),
		.wr_data (wr_beat),
		.rd      (fifo_rd),
		.rd_data (head),
		.empty   (fifo_empty),
		.full    (out_full)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			tag_wr       <= 1'b0;
			out_valid    <= 1'b0;
			tag_data_out <= 1'b0;
		end else begin
			tag_wr <= ghash_done;                // Tag goes in behind the ciphertext
			if (fifo_rd) begin
				out_valid    <= 1'b1;
				tag_data_out <= head.is_tag;
			end else if (ready_to_out) begin
				out_valid    <= 1'b0;            // Beat taken, nothing behind it
				tag_data_out <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_rd)
			out_data <= head.data;              // Held until taken
	end

endmodule

`default_nettype wire

/* tb_gcm_enc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gcm_enc;

	import gcm_pkg::*;

	typedef struct packed {
		logic [95:0] iv;
		logic [15:0] aad_bits;
		logic [15:0] pt_bits;
		logic [31:0] seed;      // Mixed into the data generator per message
	} msg_t;

	localparam logic [31:0] SEED = 32'h7dd8_7893;
	localparam int          N_MSG = 6;
	localparam msg_t MSGS [N_MSG] = '{
		'{96'hcafebabe_facedbad_decaf888, 16'd256, 16'd512,  32'h0000_1001},  // Full blocks
		'{96'h01234567_89abcdef_00112233, 16'd100, 16'd300,  32'h0000_2002},  // Partial tails
		'{96'hfeedf00d_0badc0de_13579bdf, 16'd0,   16'd1024, 32'h0000_3003},  // No AAD, max PT
		'{96'h2468ace0_11223344_55667788, 16'd128, 16'd0,    32'h0000_4004},  // No plaintext
		'{96'h99aabbcc_ddeeff00_a5a5a5a5, 16'd0,   16'd0,    32'h0000_5005},  // Empty message
		'{96'h0f1e2d3c_4b5a6978_8796a5b4, 16'd64,  16'd8,    32'h0000_6006}
	};

	logic        clk;
	logic        reset;
	block_t      in_data;
	logic        in_valid;
	logic        ready_for_inp;
	block_t      out_data;
	logic        out_valid;
	logic        tag_data_out;
	logic        ready_to_out = 1'b0;
	logic        cipher_req;
	block_t      cipher_block;
	logic        cipher_ack = 1'b0;
	block_t      keystream = '0;

	logic [31:0] data_state;
	logic [31:0] bp_state  = SEED;
	logic [31:0] ack_state = SEED ^ 32'h5a5a_a5a5;  // Separate stream for cipher delays
	block_t      words [$];                          // Input words of the current message
	block_t      req_exp [$];                        // Cipher blocks in the order they are due
	block_t      exp_ct [PT_MAX_BLOCKS];
	block_t      exp_tag;
	block_t      req_q;
	int          n_ct, ack_wait = 0, zero_reqs = 0;
	int          checks = 0, errors = 0, err_before;

	gcm_enc_top i_gcm_enc_top (
		.clk (clk), .reset (reset),
		.in_data (in_data), .in_valid (in_valid), .ready_for_inp (ready_for_inp),
		.out_data (out_data), .out_valid (out_valid), .tag_data_out (tag_data_out),
		.ready_to_out (ready_to_out),
		.cipher_req (cipher_req), .cipher_block (cipher_block),
		.cipher_ack (cipher_ack), .keystream (keystream)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		data_state = xorshift(data_state);
		return data_state;
	endfunction

	function automatic block_t rand_block();
		block_t b;
		for (int i = 0; i < 4; i++)
			b[32*i +: 32] = next_rand();
		return b;
	endfunction

	// Stand-in block cipher, any fixed bijection-like map will do
	function automatic block_t mix(input block_t blk);
		logic [31:0] s;
		block_t      ks;
		s = blk[127:96] ^ blk[95:64] ^ blk[63:32] ^ blk[31:0] ^ 32'h9e37_79b9;
		if (s == '0)
			s = 32'h1;
		for (int i = 0; i < 4; i++) begin
			s = xorshift(s);
			ks[32*i +: 32] = s ^ blk[32*i +: 32];
		end
		return ks;
	endfunction

	// GCM multiply, vector MSB is GCM bit 0
	function automatic block_t gf_mul(input block_t x, input block_t y);
		block_t z, v;
		z = '0;
		v = y;
		for (int i = 0; i < 128; i++) begin
			if (x[127 - i])
				z = z ^ v;
			v = v[0] ? ((v >> 1) ^ {8'he1, 120'd0}) : (v >> 1);
		end
		return z;
	endfunction

	// GCM bits of block idx that lie inside a section of the given bit length
	function automatic block_t keep_mask(input int bits, input int idx);
		block_t m;
		for (int i = 0; i < 128; i++)
			m[127 - i] = (i < bits - 128 * idx);
		return m;
	endfunction

	task automatic check(input string name, input block_t got, input block_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Builds the input words, expected beats and expected cipher requests
	task automatic build_message(input msg_t msg);
		block_t h, y, blk, size_word;
		int     n_aad;
		h         = mix('0);
		y         = '0;
		data_state = SEED ^ msg.seed;
		size_word = {48'd0, msg.aad_bits, 48'd0, msg.pt_bits};  // Also the length block
		n_aad     = (msg.aad_bits + 127) / 128;
		n_ct      = (msg.pt_bits + 127) / 128;
		words     = {};
		words.push_back({msg.iv, next_rand()});  // Low word of the IV word is ignored
		words.push_back(size_word);
		req_exp.push_back({msg.iv, 32'd1});      // J0
		for (int i = 0; i < n_aad; i++) begin
			blk = rand_block() & keep_mask(msg.aad_bits, i);  // Zero padded AAD
			words.push_back(blk);
			y = gf_mul(y ^ blk, h);
		end
		for (int i = 0; i < n_ct; i++) begin
			blk = rand_block();                  // Junk past the length must not leak
			words.push_back(blk);
			req_exp.push_back({msg.iv, 32'(i + 2)});
			exp_ct[i] = (blk ^ mix({msg.iv, 32'(i + 2)})) & keep_mask(msg.pt_bits, i);
			y = gf_mul(y ^ exp_ct[i], h);
		end
		exp_tag = gf_mul(y ^ size_word, h) ^ mix({msg.iv, 32'd1});
	endtask

	task automatic send_word(input block_t w);
		in_data  <= w;
		in_valid <= 1'b1;
		@(posedge clk);
		while (!ready_for_inp)
			@(posedge clk);
	endtask

	// Takes beats until the tag, every beat checked in order
	task automatic collect_beats(input int n);
		int idx;
		bit got_tag;
		idx     = 0;
		got_tag = 1'b0;
		while (!got_tag) begin
			@(posedge clk);
			if (out_valid && ready_to_out) begin
				check("out_data", out_data, (idx < n) ? exp_ct[idx] : exp_tag);
				check("tag_data_out", block_t'(tag_data_out), block_t'(idx == n));
				got_tag = tag_data_out;
				idx++;
			end
		end
		check("beat count", block_t'(idx), block_t'(n + 1));
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		bp_state = xorshift(bp_state);
		ready_to_out <= (bp_state[1:0] != 2'b00);  // Low about one cycle in four
	end

	// Cipher model, answers 1 to 4 cycles after each request
	always @(posedge clk) begin
		cipher_ack <= 1'b0;
		if (ack_wait > 0) begin
			ack_wait--;
			if (ack_wait == 0) begin
				cipher_ack <= 1'b1;
				keystream  <= mix(req_q);
			end
		end
		if (cipher_req) begin
			if (req_exp.size() == 0) begin
				errors++;
				$display("Unexpected cipher request at %0t ns, none was due", $time);
			end else begin
				check("cipher_block", cipher_block, req_exp.pop_front());
			end
			if (cipher_block == '0)
				zero_reqs++;
			req_q     = cipher_block;
			ack_state = xorshift(ack_state);
			ack_wait  = 1 + ack_state[1:0];
		end
	end

	initial begin
		#(N_MSG * 10 * 200 * 4);                 // Messages x 10 blocks x 200 cycles
		$display("Timeout, the run did not end within %0d ns", N_MSG * 10 * 200 * 4);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		reset    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		req_exp.push_back('0);                   // H = E(0) comes first
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		check("out_valid", block_t'(out_valid), '0);
		check("tag_data_out", block_t'(tag_data_out), '0);
		check("cipher_req", block_t'(cipher_req), '0);
		check("ready_for_inp", block_t'(ready_for_inp), '0);
		for (int m = 0; m < N_MSG; m++) begin
			err_before = errors;
			build_message(MSGS[m]);
			fork
				begin
					foreach (words[i])
						send_word(words[i]);
					in_valid <= 1'b0;
				end
				collect_beats(n_ct);
			join
			$display("Message %0d aad %0d bits pt %0d bits %0d beats %s", m,
				MSGS[m].aad_bits, MSGS[m].pt_bits, n_ct + 1,
				(errors == err_before) ? "ok" : "mismatch");
		end
		check("zero block requests", block_t'(zero_reqs), block_t'(1));
		if (i_gcm_enc_top.i_gcm_enc_asserts.assert_fails != 0) begin
			errors += i_gcm_enc_top.i_gcm_enc_asserts.assert_fails;
			$display("Bound assertions failed %0d times",
				i_gcm_enc_top.i_gcm_enc_asserts.assert_fails);
		end
		$display("%0d messages %0d checks %0d errors", N_MSG, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
